/* hdl/tri_lb_pkg.sv */
package tri_lb_pkg;

    // memory word and vertex attribute width
    parameter int DATA_W = 32;
    // main memory address width
    parameter int ADDR_W = 32;
    // attribute index and vertex size field width
    parameter int ATTR_W = 4;

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ATTR_W-1:0] attr_t;

    // local vertex slot, only 0 to 2 are used
    typedef logic [1:0] slot_t;

    typedef enum logic {
        POLY_TRIANGLES = 1'b0,
        POLY_STRIP     = 1'b1
    } poly_mode_e;

    // slot read order for the three emit positions
    typedef enum logic [2:0] {
        ORDER_ABC = 3'd0,
        ORDER_ACB = 3'd1,
        ORDER_CAB = 3'd2,
        ORDER_CBA = 3'd3,
        ORDER_BCA = 3'd4,
        ORDER_BAC = 3'd5
    } read_order_e;

endpackage

/* hdl/vertex_slot_ram.sv */
module vertex_slot_ram import tri_lb_pkg::*; (
    input  logic  clk,
    input  logic  resetn,
    input  slot_t i_wr_slot,
    input  attr_t i_wr_attr,
    input  word_t i_wr_data,
    input  logic  i_wr_en,
    input  slot_t i_rd_slot,
    input  attr_t i_rd_attr,
    input  logic  i_rd_en,
    output word_t o_rd_data
);

    localparam int DEPTH = 2 ** ATTR_W;

    // one bank per local vertex
    word_t bank_mem [0:2][0:DEPTH-1];

    always_ff @(posedge clk) begin
        if (i_wr_en && (i_wr_slot != 2'd3)) begin
            bank_mem[i_wr_slot][i_wr_attr] <= i_wr_data;
        end
    end

    // registered read, data one cycle after the strobe
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            o_rd_data <= '0;
        end else if (i_rd_en && (i_rd_slot != 2'd3)) begin
            o_rd_data <= bank_mem[i_rd_slot][i_rd_attr];
        end
    end

endmodule

/* hdl/strip_read_order.sv */
module strip_read_order import tri_lb_pkg::*; (
    input  logic       clk,
    input  logic       resetn,
    input  poly_mode_e i_mode,
    input  logic       i_job_start,
    input  logic       i_tri_done,
    input  slot_t      i_emit_pos,
    output slot_t      o_rd_slot
);

    read_order_e order_q;
    read_order_e order_eff;
    // slots for emit positions 2, 1, 0
    logic [5:0]  perm;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            order_q <= ORDER_ABC;
        end else if (i_job_start) begin
            order_q <= ORDER_ABC;
        end else if (i_tri_done && (i_mode == POLY_STRIP)) begin
            case (order_q)
                ORDER_ABC: order_q <= ORDER_ACB;
                ORDER_ACB: order_q <= ORDER_CAB;
                ORDER_CAB: order_q <= ORDER_CBA;
                ORDER_CBA: order_q <= ORDER_BCA;
                ORDER_BCA: order_q <= ORDER_BAC;
                default:   order_q <= ORDER_ABC;
            endcase
        end
    end

    // individual triangles always read slots in order
    assign order_eff = (i_mode == POLY_STRIP) ? order_q : ORDER_ABC;

    always_comb begin
        case (order_eff)
            ORDER_ACB: perm = {2'd1, 2'd2, 2'd0};
            ORDER_CAB: perm = {2'd1, 2'd0, 2'd2};
            ORDER_CBA: perm = {2'd0, 2'd1, 2'd2};
            ORDER_BCA: perm = {2'd0, 2'd2, 2'd1};
            ORDER_BAC: perm = {2'd2, 2'd0, 2'd1};
            default:   perm = {2'd2, 2'd1, 2'd0};
        endcase
        case (i_emit_pos)
            2'd1:    o_rd_slot = perm[3:2];
            2'd2:    o_rd_slot = perm[5:4];
            default: o_rd_slot = perm[1:0];
        endcase
    end

endmodule

/* hdl/fifo_dispatch.sv */
module fifo_dispatch import tri_lb_pkg::*; #(
    parameter int NUM_PIPES = 2
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  i_job_start,
    input  logic                  i_word_req,
    input  logic                  i_word_last,
    input  word_t                 i_rd_data,
    input  logic [NUM_PIPES-1:0]  i_fifo_full,
    output logic                  o_pipe_full,
    output word_t [NUM_PIPES-1:0] o_fifo_wr_data,
    output logic [NUM_PIPES-1:0]  o_fifo_wr_en
);

    localparam int SEL_W = (NUM_PIPES > 1) ? $clog2(NUM_PIPES) : 1;

    logic [SEL_W-1:0] sel_q;
    logic             req_d;
    logic             last_d;

    // request and last flag line up with the registered slot read
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            req_d  <= 1'b0;
            last_d <= 1'b0;
        end else begin
            req_d  <= i_word_req;
            last_d <= i_word_last;
        end
    end

    // next pipe once the last word of a triangle is written
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            sel_q <= '0;
        end else if (i_job_start) begin
            sel_q <= '0;
        end else if (req_d && last_d) begin
            sel_q <= (sel_q == SEL_W'(NUM_PIPES - 1)) ? '0 : sel_q + SEL_W'(1);
        end
    end

    assign o_pipe_full = i_fifo_full[sel_q];

    always_comb begin
        o_fifo_wr_en        = '0;
        o_fifo_wr_en[sel_q] = req_d;
        for (int p = 0; p < NUM_PIPES; p++) begin
            o_fifo_wr_data[p] = i_rd_data;
        end
    end

endmodule

/* hdl/tri_fetch_ctrl.sv */
module tri_fetch_ctrl import tri_lb_pkg::*; #(
    parameter int MEM_LATENCY = 2
) (
    input  logic       clk,
    input  logic       resetn,
    input  logic       i_start,
    input  poly_mode_e i_mode,
    input  addr_t      i_v_array_ptr,
    input  addr_t      i_i_array_ptr,
    input  attr_t      i_vertex_size,
    input  addr_t      i_num_tris,
    input  word_t      i_mem_rd_data,
    input  logic       i_pipe_full,
    input  slot_t      i_rd_slot,
    output logic       o_ready,
    output logic       o_done,
    output addr_t      o_mem_rd_addr,
    output logic       o_mem_rd_en,
    output logic       o_job_start,
    output slot_t      o_wr_slot,
    output attr_t      o_wr_attr,
    output word_t      o_wr_data,
    output logic       o_wr_en,
    output slot_t      o_emit_pos,
    output attr_t      o_rd_attr,
    output logic       o_word_req,
    output logic       o_word_last,
    output logic       o_tri_done
);

    localparam int LAT_W = $clog2(MEM_LATENCY + 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_TRI,
        S_IDX_RD,
        S_IDX_WAIT,
        S_ATTR_RD,
        S_ATTR_WAIT,
        S_ATTR_CAP,
        S_EMIT
    } state_e;

    state_e           state_q;
    addr_t            tri_cnt_q;
    addr_t            idx_pos_q;
    attr_t            attr_idx_q;
    logic [LAT_W-1:0] lat_cnt_q;
    slot_t            wr_slot_q;
    logic [1:0]       vtx_left_q;
    word_t            vtx_idx_q;
    slot_t            emit_pos_q;
    attr_t            rd_attr_q;
    logic             done_q;
    word_t            vtx_idx;
    addr_t            vtx_stride;
    logic             oldest_rd;

    // index word is still on the bus while the first attribute read goes out
    assign vtx_idx    = (attr_idx_q == '0) ? i_mem_rd_data : vtx_idx_q;
    assign vtx_stride = addr_t'(i_vertex_size) + addr_t'(1);

    always_comb begin
        o_mem_rd_en   = (state_q == S_IDX_RD) || (state_q == S_ATTR_RD);
        o_mem_rd_addr = i_i_array_ptr + idx_pos_q;
        if (state_q == S_ATTR_RD) begin
            o_mem_rd_addr = i_v_array_ptr + addr_t'(vtx_idx) * vtx_stride
                            + addr_t'(attr_idx_q);
        end
    end

    assign o_ready     = (state_q == S_IDLE);
    assign o_job_start = o_ready && i_start;
    assign o_done      = done_q;

    assign o_wr_en   = (state_q == S_ATTR_CAP);
    assign o_wr_slot = wr_slot_q;
    assign o_wr_attr = attr_idx_q;
    assign o_wr_data = i_mem_rd_data;

    assign o_emit_pos  = emit_pos_q;
    assign o_rd_attr   = rd_attr_q;
    assign o_word_req  = (state_q == S_EMIT) && !i_pipe_full;
    assign o_word_last = (state_q == S_EMIT) && (emit_pos_q == 2'd2)
                         && (rd_attr_q == i_vertex_size);
    assign o_tri_done  = o_word_req && o_word_last;

    // next strip vertex replaces position k, read first on even and last on odd triangles
    assign oldest_rd = (i_mode == POLY_STRIP) && o_word_req && (rd_attr_q == '0)
                       && (emit_pos_q == (tri_cnt_q[0] ? 2'd2 : 2'd0));

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q    <= S_IDLE;
            tri_cnt_q  <= '0;
            idx_pos_q  <= '0;
            attr_idx_q <= '0;
            lat_cnt_q  <= '0;
            wr_slot_q  <= '0;
            vtx_left_q <= '0;
            vtx_idx_q  <= '0;
            emit_pos_q <= '0;
            rd_attr_q  <= '0;
            done_q     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (i_start) begin
                        tri_cnt_q  <= '0;
                        idx_pos_q  <= '0;
                        attr_idx_q <= '0;
                        wr_slot_q  <= '0;
                        state_q    <= S_TRI;
                    end
                end
                S_TRI: begin
                    if (tri_cnt_q == i_num_tris) begin
                        done_q  <= 1'b1;
                        state_q <= S_IDLE;
                    end else begin
                        // strip triangles after the first keep two vertices
                        vtx_left_q <= (i_mode == POLY_STRIP && tri_cnt_q != '0) ? 2'd0 : 2'd2;
                        state_q    <= S_IDX_RD;
                    end
                end
                S_IDX_RD: begin
                    lat_cnt_q <= LAT_W'(1);
                    state_q   <= S_IDX_WAIT;
                end
                S_IDX_WAIT: begin
                    if (lat_cnt_q == LAT_W'(MEM_LATENCY)) begin
                        state_q <= S_ATTR_RD;
                    end else begin
                        lat_cnt_q <= lat_cnt_q + LAT_W'(1);
                    end
                end
                S_ATTR_RD: begin
                    if (attr_idx_q == '0) begin
                        vtx_idx_q <= i_mem_rd_data;
                    end
                    lat_cnt_q <= LAT_W'(1);
                    state_q   <= S_ATTR_WAIT;
                end
                S_ATTR_WAIT: begin
                    if (lat_cnt_q == LAT_W'(MEM_LATENCY)) begin
                        state_q <= S_ATTR_CAP;
                    end else begin
                        lat_cnt_q <= lat_cnt_q + LAT_W'(1);
                    end
                end
                S_ATTR_CAP: begin
                    if (attr_idx_q != i_vertex_size) begin
                        attr_idx_q <= attr_idx_q + attr_t'(1);
                        state_q    <= S_ATTR_RD;
                    end else begin
                        attr_idx_q <= '0;
                        idx_pos_q  <= idx_pos_q + addr_t'(1);
                        wr_slot_q  <= (wr_slot_q == 2'd2) ? 2'd0 : wr_slot_q + 2'd1;
                        if (vtx_left_q == 2'd0) begin
                            emit_pos_q <= '0;
                            rd_attr_q  <= '0;
                            state_q    <= S_EMIT;
                        end else begin
                            vtx_left_q <= vtx_left_q - 2'd1;
                            state_q    <= S_IDX_RD;
                        end
                    end
                end
                S_EMIT: begin
                    if (o_word_req) begin
                        if (oldest_rd) begin
                            wr_slot_q <= i_rd_slot;
                        end
                        if (rd_attr_q != i_vertex_size) begin
                            rd_attr_q <= rd_attr_q + attr_t'(1);
                        end else begin
                            rd_attr_q <= '0;
                            if (emit_pos_q == 2'd2) begin
                                tri_cnt_q <= tri_cnt_q + addr_t'(1);
                                state_q   <= S_TRI;
                            end else begin
                                emit_pos_q <= emit_pos_q + 2'd1;
                            end
                        end
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

endmodule

/* hdl/tri_load_balancer.sv */
module tri_load_balancer import tri_lb_pkg::*; #(
    parameter int NUM_PIPES   = 2,
    parameter int MEM_LATENCY = 2
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       i_start,
    input  poly_mode_e                 i_mode,
    input  addr_t                      i_v_array_ptr,
    input  addr_t                      i_i_array_ptr,
    input  attr_t                      i_vertex_size,
    input  addr_t                      i_num_tris,
    input  word_t                      i_mem_rd_data,
    input  logic [NUM_PIPES-1:0]       i_fifo_full,
    output logic                       o_ready,
    output logic                       o_done,
    output addr_t                      o_mem_rd_addr,
    output logic                       o_mem_rd_en,
    output word_t [NUM_PIPES-1:0]      o_fifo_wr_data,
    output logic [NUM_PIPES-1:0]       o_fifo_wr_en
);

    logic  job_start;
    logic  pipe_full;
    slot_t rd_slot;

    // vertex slot write side
    slot_t wr_slot;
    attr_t wr_attr;
    word_t wr_data;
    logic  wr_en;

    // emission side
    slot_t emit_pos;
    attr_t rd_attr;
    logic  word_req;
    logic  word_last;
    logic  tri_done;
    word_t rd_data;

    tri_fetch_ctrl #(
        .MEM_LATENCY(MEM_LATENCY)
    ) u_ctrl (
        .clk(clk),
        .resetn(resetn),
        .i_start(i_start),
        .i_mode(i_mode),
        .i_v_array_ptr(i_v_array_ptr),
        .i_i_array_ptr(i_i_array_ptr),
        .i_vertex_size(i_vertex_size),
        .i_num_tris(i_num_tris),
        .i_mem_rd_data(i_mem_rd_data),
        .i_pipe_full(pipe_full),
        .i_rd_slot(rd_slot),
        .o_ready(o_ready),
        .o_done(o_done),
        .o_mem_rd_addr(o_mem_rd_addr),
        .o_mem_rd_en(o_mem_rd_en),
        .o_job_start(job_start),
        .o_wr_slot(wr_slot),
        .o_wr_attr(wr_attr),
        .o_wr_data(wr_data),
        .o_wr_en(wr_en),
        .o_emit_pos(emit_pos),
        .o_rd_attr(rd_attr),
        .o_word_req(word_req),
        .o_word_last(word_last),
        .o_tri_done(tri_done)
    );

    vertex_slot_ram u_slots (
        .clk(clk),
        .resetn(resetn),
        .i_wr_slot(wr_slot),
        .i_wr_attr(wr_attr),
        .i_wr_data(wr_data),
        .i_wr_en(wr_en),
        .i_rd_slot(rd_slot),
        .i_rd_attr(rd_attr),
        .i_rd_en(word_req),
        .o_rd_data(rd_data)
    );

    strip_read_order u_order (
        .clk(clk),
        .resetn(resetn),
        .i_mode(i_mode),
        .i_job_start(job_start),
        .i_tri_done(tri_done),
        .i_emit_pos(emit_pos),
        .o_rd_slot(rd_slot)
    );

    fifo_dispatch #(
        .NUM_PIPES(NUM_PIPES)
    ) u_dispatch (
        .clk(clk),
        .resetn(resetn),
        .i_job_start(job_start),
        .i_word_req(word_req),
        .i_word_last(word_last),
        .i_rd_data(rd_data),
        .i_fifo_full(i_fifo_full),
        .o_pipe_full(pipe_full),
        .o_fifo_wr_data(o_fifo_wr_data),
        .o_fifo_wr_en(o_fifo_wr_en)
    );

endmodule

/* tb/main_mem_model.sv */
module main_mem_model #(
    parameter int MEM_LATENCY = 2,
    parameter int MEM_AW      = 10
) (
    input  logic        clk,
    input  logic        resetn,
    input  logic        i_rd_en,
    input  logic [31:0] i_rd_addr,
    output logic [31:0] o_rd_data
);

    // word array, filled by the testbench
    logic [31:0]            mem [0:2**MEM_AW-1];
    logic [31:0]            data_pipe [0:MEM_LATENCY-1];
    logic [MEM_LATENCY-1:0] valid_pipe;
    logic [31:0]            hold_q;

    always_ff @(posedge clk) begin
        data_pipe[0] <= mem[i_rd_addr[MEM_AW-1:0]];
        for (int i = 1; i < MEM_LATENCY; i++) begin
            data_pipe[i] <= data_pipe[i-1];
        end
    end

    // last returned word stays on the bus until the next read returns
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            valid_pipe <= '0;
            hold_q     <= '0;
        end else begin
            valid_pipe[0] <= i_rd_en;
            for (int i = 1; i < MEM_LATENCY; i++) begin
                valid_pipe[i] <= valid_pipe[i-1];
            end
            if (valid_pipe[MEM_LATENCY-1]) begin
                hold_q <= data_pipe[MEM_LATENCY-1];
            end
        end
    end

    assign o_rd_data = valid_pipe[MEM_LATENCY-1] ? data_pipe[MEM_LATENCY-1] : hold_q;

endmodule

/* tb/tb_tri_load_balancer.sv */
module tb_tri_load_balancer import tri_lb_pkg::*; #(
    parameter int NUM_PIPES   = 2,
    parameter int MEM_LATENCY = 2
);

    localparam int NUM_JOBS = 14;
    localparam int MEM_AW   = 10;

    logic                  clk;
    logic                  resetn;
    logic                  start;
    poly_mode_e            mode;
    addr_t                 v_ptr;
    addr_t                 i_ptr;
    attr_t                 vtx_size;
    addr_t                 num_tris;
    word_t                 mem_rd_data;
    logic [NUM_PIPES-1:0]  fifo_full;
    logic                  ready;
    logic                  done;
    addr_t                 mem_rd_addr;
    logic                  mem_rd_en;
    word_t [NUM_PIPES-1:0] fifo_wr_data;
    logic [NUM_PIPES-1:0]  fifo_wr_en;

    // expected words per pipe in write order
    word_t      exp_q [NUM_PIPES][$];
    // expected main memory read addresses in issue order
    addr_t      exp_addr_q [$];
    poly_mode_e job_mode [NUM_JOBS];
    int         job_tris [NUM_JOBS];
    int         job_vs [NUM_JOBS];
    logic       job_bp [NUM_JOBS];
    logic       bp_on = 1'b0;
    int         errors = 0;
    int         checks = 0;
    int         rd_count = 0;
    int         done_count = 0;
    int         cycles = 0;
    int         cycle_limit = 0;

    tri_load_balancer #(
        .NUM_PIPES(NUM_PIPES),
        .MEM_LATENCY(MEM_LATENCY)
    ) dut (
        .clk(clk),
        .resetn(resetn),
        .i_start(start),
        .i_mode(mode),
        .i_v_array_ptr(v_ptr),
        .i_i_array_ptr(i_ptr),
        .i_vertex_size(vtx_size),
        .i_num_tris(num_tris),
        .i_mem_rd_data(mem_rd_data),
        .i_fifo_full(fifo_full),
        .o_ready(ready),
        .o_done(done),
        .o_mem_rd_addr(mem_rd_addr),
        .o_mem_rd_en(mem_rd_en),
        .o_fifo_wr_data(fifo_wr_data),
        .o_fifo_wr_en(fifo_wr_en)
    );

    main_mem_model #(
        .MEM_LATENCY(MEM_LATENCY),
        .MEM_AW(MEM_AW)
    ) u_mem (
        .clk(clk),
        .resetn(resetn),
        .i_rd_en(mem_rd_en),
        .i_rd_addr(mem_rd_addr),
        .o_rd_data(mem_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_value(input string name, input word_t expected, input word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("FAIL %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    function automatic word_t mem_word(input addr_t addr);
        return u_mem.mem[addr[MEM_AW-1:0]];
    endfunction

    task automatic write_word(input addr_t addr, input word_t data);
        u_mem.mem[addr[MEM_AW-1:0]] = data;
    endtask

    // job list and the run limit that follows from it
    task automatic plan_jobs();
        for (int j = 0; j < NUM_JOBS; j++) begin
            job_mode[j] = (j < NUM_JOBS / 2) ? POLY_TRIANGLES : POLY_STRIP;
            job_tris[j] = (j == NUM_JOBS - 1) ? 0 : 1 + int'($urandom % 6);
            job_vs[j]   = int'($urandom % 4);
            job_bp[j]   = (j % 2) == 1;
            cycle_limit += 40 * job_tris[j] * (job_vs[j] + 1) + 100;
        end
    endtask

    // strip triangle k uses positions k..k+2, odd k in descending order
    task automatic build_expected(input int j);
        int    pos;
        int    pipe;
        word_t vtx;
        addr_t addr;
        for (int k = 0; k < job_tris[j]; k++) begin
            pipe = k % NUM_PIPES;
            for (int e = 0; e < 3; e++) begin
                if (job_mode[j] == POLY_TRIANGLES) begin
                    pos = 3 * k + e;
                end else if (k % 2 == 0) begin
                    pos = k + e;
                end else begin
                    pos = k + 2 - e;
                end
                vtx = mem_word(i_ptr + addr_t'(pos));
                for (int a = 0; a <= job_vs[j]; a++) begin
                    addr = v_ptr + vtx * addr_t'(job_vs[j] + 1) + addr_t'(a);
                    exp_q[pipe].push_back(mem_word(addr));
                end
            end
        end
    endtask

    // vertices are fetched in ascending index position
    task automatic list_read_addrs(input int j, input int n_fetch);
        word_t vtx;
        exp_addr_q.delete();
        for (int p = 0; p < n_fetch; p++) begin
            vtx = mem_word(i_ptr + addr_t'(p));
            exp_addr_q.push_back(i_ptr + addr_t'(p));
            for (int a = 0; a <= job_vs[j]; a++) begin
                exp_addr_q.push_back(v_ptr + vtx * addr_t'(job_vs[j] + 1) + addr_t'(a));
            end
        end
    endtask

    task automatic run_job(input int j);
        int n_idx;
        int exp_reads;
        mode     = job_mode[j];
        num_tris = addr_t'(job_tris[j]);
        vtx_size = attr_t'(job_vs[j]);
        i_ptr    = 32'h40 + ($urandom % 32);
        v_ptr    = 32'h200 + ($urandom % 64);
        n_idx    = (mode == POLY_STRIP) ? job_tris[j] + 2 : 3 * job_tris[j];
        // each fetched vertex costs one index read plus its attribute reads
        exp_reads = (job_tris[j] == 0) ? 0 : n_idx * (job_vs[j] + 2);
        for (int p = 0; p < n_idx; p++) begin
            write_word(i_ptr + addr_t'(p), $urandom % 16);
        end
        build_expected(j);
        list_read_addrs(j, (job_tris[j] == 0) ? 0 : n_idx);
        bp_on    = job_bp[j];
        rd_count = 0;
        start    = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_value("o_ready", 0, word_t'(ready));
        while (!done) begin
            @(negedge clk);
        end
        bp_on = 1'b0;
        check_value("o_ready", 1, word_t'(ready));
        check_value("mem_rd_en count", exp_reads, rd_count);
        for (int p = 0; p < NUM_PIPES; p++) begin
            check_value($sformatf("pipe %0d words left", p), 0, exp_q[p].size());
        end
        repeat (2) @(negedge clk);
        check_value("o_done count", j + 1, done_count);
    endtask

    // output monitor
    always @(negedge clk) begin
        if (resetn) begin
            if (mem_rd_en) begin
                rd_count++;
                if (exp_addr_q.size() == 0) begin
                    errors++;
                    $display("unexpected memory read at time %0t", $time);
                end else begin
                    check_value("o_mem_rd_addr", exp_addr_q.pop_front(), mem_rd_addr);
                end
            end
            if (done) begin
                done_count++;
            end
            if ($countones(fifo_wr_en) > 1) begin
                errors++;
                $display("more than one pipe written in the same cycle at time %0t", $time);
            end
            for (int p = 0; p < NUM_PIPES; p++) begin
                if (fifo_wr_en[p] && exp_q[p].size() == 0) begin
                    errors++;
                    $display("unexpected write on pipe %0d at time %0t", p, $time);
                end else if (fifo_wr_en[p]) begin
                    check_value($sformatf("o_fifo_wr_data[%0d]", p), exp_q[p].pop_front(),
                                fifo_wr_data[p]);
                end
            end
        end
    end

    // random full levels while back-pressure is on
    always @(negedge clk) begin
        for (int p = 0; p < NUM_PIPES; p++) begin
            fifo_full[p] = bp_on && ($urandom % 3 == 0);
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the DUT did not finish its jobs", cycles);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(32'hec89_8426));
        resetn    = 1'b0;
        start     = 1'b0;
        mode      = POLY_TRIANGLES;
        v_ptr     = '0;
        i_ptr     = '0;
        vtx_size  = '0;
        num_tris  = '0;
        fifo_full = '0;
        plan_jobs();
        for (int a = 0; a < 2 ** MEM_AW; a++) begin
            write_word(addr_t'(a), $urandom);
        end
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        @(negedge clk);
        check_value("o_ready", 1, word_t'(ready));
        check_value("o_done", 0, word_t'(done));
        check_value("o_mem_rd_en", 0, word_t'(mem_rd_en));
        check_value("o_fifo_wr_en", 0, word_t'(fifo_wr_en));
        for (int j = 0; j < NUM_JOBS; j++) begin
            run_job(j);
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* src.f */
hdl/tri_lb_pkg.sv
hdl/vertex_slot_ram.sv
hdl/strip_read_order.sv
hdl/fifo_dispatch.sv
hdl/tri_fetch_ctrl.sv
hdl/tri_load_balancer.sv
tb/main_mem_model.sv
tb/tb_tri_load_balancer.sv

/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f src.f --top-module tb_tri_load_balancer -o tb_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/tb_sim > sim.log 2>&1 || { cat sim.log; echo "simulator exited with an error"; exit 1; }
cat sim.log
grep -q "Testbench failed" sim.log && { echo "simulation reported failure"; exit 1; }
exit 0
